// File: hdl/l2_config.svh
// ========================================
// L2 scratchpad configuration
// Address and data widths, bank geometry
// and the base of each address view
// ========================================

`ifndef L2_CONFIG_SVH
`define L2_CONFIG_SVH

`define L2_ADDR_W      16
`define L2_DATA_W      32
`define L2_NUM_BANKS   2
`define L2_BANK_ROWS   64

// View bases
`define L2_INTL_BASE   16'h0000
`define L2_NINT_BASE   16'h1000

// Derived sizes
`define L2_ROW_W       ($clog2(`L2_BANK_ROWS))
`define L2_BANK_W      ($clog2(`L2_NUM_BANKS))
`define L2_VIEW_BYTES  (`L2_NUM_BANKS * `L2_BANK_ROWS * (`L2_DATA_W / 8))

`endif

// File: hdl/l2_pkg.sv
// ========================================
// L2 scratchpad types
// Request, response, map view and the
// decoded access passed to the banks
// ========================================

`include "l2_config.svh"

package l2_pkg;

  // Request port payload
  typedef struct packed {
    logic                  we;
    logic [`L2_ADDR_W-1:0] addr;
    logic [`L2_DATA_W-1:0] wdata;
  } l2_req_t;

  // Read response payload
  typedef struct packed {
    logic [`L2_DATA_W-1:0] rdata;
    logic                  err;
  } l2_rsp_t;

  // Two views of the same storage
  typedef enum logic {
    INTERLEAVE = 1'b0,
    NONE_INTER = 1'b1
  } l2_map_mode_e;

  // Decoded access, one cycle after the request
  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic                  err;
    logic [`L2_BANK_W-1:0] bank;
    logic [`L2_ROW_W-1:0]  row;
    logic [`L2_DATA_W-1:0] wdata;
  } l2_access_t;

endpackage

// File: hdl/l2_addr_map.sv
// ========================================
// L2 address decoder
// Matches a request against the two views
// and registers bank, row and error flag
// ========================================

`timescale 1ns/10ps
`include "l2_config.svh"

module l2_addr_map (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                accept_i,
  input  logic                req_valid_i,
  input  l2_pkg::l2_req_t     req_i,
  output l2_pkg::l2_access_t  acc_o
);

  typedef struct packed {
    l2_pkg::l2_map_mode_e  mode;
    logic [`L2_ADDR_W-1:0] start_addr;
    logic [`L2_ADDR_W-1:0] end_addr;
  } map_rule_t;

  localparam int unsigned NumRules = 2;
  localparam logic [`L2_ADDR_W-1:0] ViewBytes = `L2_ADDR_W'(`L2_VIEW_BYTES);

  localparam map_rule_t [NumRules-1:0] MapRules = '{
    '{mode: l2_pkg::NONE_INTER, start_addr: `L2_NINT_BASE,
      end_addr: `L2_NINT_BASE + ViewBytes},
    '{mode: l2_pkg::INTERLEAVE, start_addr: `L2_INTL_BASE,
      end_addr: `L2_INTL_BASE + ViewBytes}
  };

  logic                               hit;
  l2_pkg::l2_map_mode_e               mode;
  logic [`L2_ADDR_W-1:0]              offset;
  logic [`L2_ROW_W+`L2_BANK_W-1:0]    word;
  logic [`L2_BANK_W-1:0]              bank;
  logic [`L2_ROW_W-1:0]               row;
  logic                               take;

  logic                               valid_q;
  logic                               we_q;
  logic                               err_q;
  logic [`L2_BANK_W-1:0]              bank_q;
  logic [`L2_ROW_W-1:0]               row_q;
  logic [`L2_DATA_W-1:0]              wdata_q;

  always_comb begin
    hit    = 1'b0;
    mode   = l2_pkg::INTERLEAVE;
    offset = '0;
    for (int i = 0; i < NumRules; i++) begin
      if (req_i.addr >= MapRules[i].start_addr && req_i.addr < MapRules[i].end_addr) begin
        hit    = 1'b1;
        mode   = MapRules[i].mode;
        offset = req_i.addr - MapRules[i].start_addr;
      end
    end
  end

  // Word index, byte lane bits dropped
  assign word = offset[`L2_ROW_W+`L2_BANK_W+1:2];

  // Two banks, so the bank is a single bit of the word index
  always_comb begin
    if (mode == l2_pkg::INTERLEAVE) begin
      bank = word[0];
      row  = word[`L2_ROW_W:1];
    end else begin
      bank = word[`L2_ROW_W];
      row  = word[`L2_ROW_W-1:0];
    end
  end

  assign take = accept_i && req_valid_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      we_q    <= req_i.we;
      err_q   <= !hit;
      bank_q  <= bank;
      row_q   <= row;
      wdata_q <= req_i.wdata;
    end
  end

  always_comb begin
    acc_o.valid = valid_q;
    acc_o.we    = we_q;
    acc_o.err   = err_q;
    acc_o.bank  = bank_q;
    acc_o.row   = row_q;
    acc_o.wdata = wdata_q;
  end

endmodule

// File: hdl/l2_init_fsm.sv
// ========================================
// L2 initialisation sequencer
// Zeroes both banks after reset or clear
// and holds requests off until done
// ========================================

`timescale 1ns/10ps

module l2_init_fsm (
  input  logic clk_i,
  input  logic reset_i,
  input  logic clear_i,
  input  logic last_i,
  output logic cnt_en_o,
  output logic clr_we_o,
  output logic ready_o
);

  typedef enum logic [1:0] {
    RESET = 2'd0,
    INIT  = 2'd1,
    READY = 2'd2
  } state_e;

  state_e state_q;
  state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RESET: begin
        state_d = INIT;
      end
      INIT: begin
        // A clear mid-sweep starts over
        if (clear_i) begin
          state_d = RESET;
        end else if (last_i) begin
          state_d = READY;
        end
      end
      READY: begin
        if (clear_i) begin
          state_d = RESET;
        end
      end
      default: begin
        state_d = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // Counter runs and rows are zeroed only while sweeping
  assign cnt_en_o = (state_q == INIT);
  assign clr_we_o = (state_q == INIT);
  assign ready_o  = (state_q == READY);

endmodule

// File: hdl/l2_row_counter.sv
// ========================================
// L2 row counter
// Walks every bank row during the clear
// sweep, flags the final row
// ========================================

`timescale 1ns/10ps
`include "l2_config.svh"

module l2_row_counter (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 en_i,
  output logic [`L2_ROW_W-1:0] row_o,
  output logic                 last_o
);

  logic [`L2_ROW_W-1:0] row_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || !en_i) begin
      row_q <= '0;
    end else if (last_o) begin
      row_q <= '0;
    end else begin
      row_q <= row_q + {{(`L2_ROW_W-1){1'b0}}, 1'b1};
    end
  end

  assign row_o  = row_q;
  assign last_o = (int'(row_q) == `L2_BANK_ROWS - 1);

endmodule

// File: hdl/l2_bank.sv
// ========================================
// L2 memory bank
// Single-port word memory with a clear
// port and registered read data
// ========================================

`timescale 1ns/10ps
`include "l2_config.svh"

module l2_bank #(
  parameter logic [`L2_BANK_W-1:0] BANK_IDX = '0
) (
  input  logic                  clk_i,
  input  l2_pkg::l2_access_t    acc_i,
  input  logic                  clr_we_i,
  input  logic [`L2_ROW_W-1:0]  clr_row_i,
  output logic [`L2_DATA_W-1:0] rdata_o
);

  logic [`L2_DATA_W-1:0] mem_q [`L2_BANK_ROWS];
  logic [`L2_DATA_W-1:0] rdata_q;
  logic                  sel;

  // Only error-free accesses aimed at this bank
  assign sel = acc_i.valid && !acc_i.err && (acc_i.bank == BANK_IDX);

  // Clear sweep wins over a regular write
  always_ff @(posedge clk_i) begin
    if (clr_we_i) begin
      mem_q[clr_row_i] <= '0;
    end else if (sel && acc_i.we) begin
      mem_q[acc_i.row] <= acc_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel && !acc_i.we) begin
      rdata_q <= mem_q[acc_i.row];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: hdl/l2_top.sv
// ========================================
// L2 scratchpad top level
// Two banks behind an interleaved and a
// non-interleaved view, zeroed on reset
// and on clear, fixed read latency of two
// ========================================

`timescale 1ns/10ps
`include "l2_config.svh"

module l2_top (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             clear_i,
  input  logic             req_valid_i,
  input  l2_pkg::l2_req_t  req_i,
  output logic             ready_o,
  output logic             rsp_valid_o,
  output l2_pkg::l2_rsp_t  rsp_o
);

  logic                  cnt_en;
  logic                  clr_we;
  logic                  row_last;
  logic [`L2_ROW_W-1:0]  clr_row;
  l2_pkg::l2_access_t    acc;

  logic [`L2_DATA_W-1:0] bank_rdata [`L2_NUM_BANKS];

  logic                  rsp_valid_q;
  logic [`L2_BANK_W-1:0] rsp_bank_q;
  logic                  rsp_err_q;

  // Requests only pass while the FSM reports ready
  l2_addr_map i_addr_map (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .accept_i    ( ready_o     ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .acc_o       ( acc         )
  );

  l2_init_fsm i_init_fsm (
    .clk_i    ( clk_i    ),
    .reset_i  ( reset_i  ),
    .clear_i  ( clear_i  ),
    .last_i   ( row_last ),
    .cnt_en_o ( cnt_en   ),
    .clr_we_o ( clr_we   ),
    .ready_o  ( ready_o  )
  );

  l2_row_counter i_row_counter (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .en_i    ( cnt_en   ),
    .row_o   ( clr_row  ),
    .last_o  ( row_last )
  );

  l2_bank #(
    .BANK_IDX ( 1'b0 )
  ) i_bank_0 (
    .clk_i     ( clk_i         ),
    .acc_i     ( acc           ),
    .clr_we_i  ( clr_we        ),
    .clr_row_i ( clr_row       ),
    .rdata_o   ( bank_rdata[0] )
  );

  l2_bank #(
    .BANK_IDX ( 1'b1 )
  ) i_bank_1 (
    .clk_i     ( clk_i         ),
    .acc_i     ( acc           ),
    .clr_we_i  ( clr_we        ),
    .clr_row_i ( clr_row       ),
    .rdata_o   ( bank_rdata[1] )
  );

  // Response follows the bank read register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= acc.valid && !acc.we;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_bank_q <= acc.bank;
    rsp_err_q  <= acc.err;
  end

  assign rsp_valid_o = rsp_valid_q;

  // Out-of-map reads return zero data
  always_comb begin
    rsp_o.err   = rsp_err_q;
    rsp_o.rdata = rsp_err_q ? '0 : bank_rdata[rsp_bank_q];
  end

endmodule

// File: dv/l2_props.sv
// ========================================
// L2 scratchpad protocol checks
// Read latency, response origin and
// readiness after reset or clear
// ========================================

`timescale 1ns/10ps

module l2_props (
  input logic            clk_i,
  input logic            reset_i,
  input logic            clear_i,
  input logic            req_valid_i,
  input l2_pkg::l2_req_t req_i,
  input logic            ready_i,
  input logic            rsp_valid_i
);

  logic rd_acc;

  // Read taken only while ready
  assign rd_acc = req_valid_i && ready_i && !req_i.we;

  rsp_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(rd_acc, 2) |-> rsp_valid_i)
    else $error("accepted read got no response two cycles later");

  rsp_needs_read: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |-> $past(rd_acc, 2))
    else $error("response without a read accepted two cycles earlier");

  ready_low_after_clear: assert property (@(posedge clk_i)
    (reset_i || clear_i) |=> !ready_i)
    else $error("ready high in the cycle after reset or clear");

endmodule

bind l2_top l2_props i_props (
  .clk_i       ( clk_i       ),
  .reset_i     ( reset_i     ),
  .clear_i     ( clear_i     ),
  .req_valid_i ( req_valid_i ),
  .req_i       ( req_i       ),
  .ready_i     ( ready_o     ),
  .rsp_valid_i ( rsp_valid_o )
);

// File: dv/l2_tb.sv
// ========================================
// L2 scratchpad testbench
// Replays the trace file against the top
// level, checks read data, error flag,
// read latency and initialisation time
// ========================================

`timescale 1ns/10ps
`include "l2_config.svh"

module l2_tb;

  localparam int ReadyTimeout = 200;
  localparam int DrainTimeout = 20;

  typedef struct packed {
    logic [`L2_DATA_W-1:0] rdata;
    logic                  err;
    logic [31:0]           cyc;
  } exp_rsp_t;

  logic            clk_i;
  logic            reset_i;
  logic            clear_i;
  logic            req_valid_i;
  l2_pkg::l2_req_t req_i;
  logic            ready_o;
  logic            rsp_valid_o;
  l2_pkg::l2_rsp_t rsp_o;

  exp_rsp_t    exp_q[$];
  logic [31:0] cyc = '0;
  int          tests = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_checks = 0;
  int          test_errors = 0;
  int          cur_test = 1;
  bit          abort = 1'b0;

  l2_top dut_i (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .clear_i     ( clear_i     ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .ready_o     ( ready_o     ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 32'd1;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    test_checks++;
    assert (got === want) else begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, want);
      test_errors++;
    end
  endtask

  task automatic wait_ready(output int waited);
    waited = 0;
    while (!ready_o && waited < ReadyTimeout) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (!ready_o) begin
      $display("Timeout at %0t: ready_o stayed low for %0d cycles", $time, waited);
      test_errors++;
      abort = 1'b1;
    end
  endtask

  task automatic issue_request(input logic we, input logic [`L2_ADDR_W-1:0] addr,
                               input logic [`L2_DATA_W-1:0] wdata);
    req_valid_i = 1'b1;
    req_i.we    = we;
    req_i.addr  = addr;
    req_i.wdata = wdata;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < DrainTimeout) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_q.size() > 0) begin
      $display("Timeout at %0t: %0d read responses never arrived", $time, exp_q.size());
      test_errors++;
      abort = 1'b1;
      exp_q.delete();
    end
  endtask

  // Clear, then strobe a write and a read that must be ignored
  task automatic run_clear(input logic [`L2_ADDR_W-1:0] addr,
                           input logic [`L2_DATA_W-1:0] wdata);
    int waited;
    clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i = 1'b0;
    check_value("ready_o", {31'd0, ready_o}, 32'd0);
    issue_request(1'b1, addr, wdata);
    issue_request(1'b0, addr, '0);
    wait_ready(waited);
    check_value("ready_o low cycles", 32'(waited + 2), 32'(`L2_BANK_ROWS + 1));
  endtask

  task automatic end_test();
    $display("Test %0d: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    tests++;
    checks += test_checks;
    errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  // Response monitor samples away from the clock edge
  always @(negedge clk_i) begin
    exp_rsp_t want;
    if (rsp_valid_o) begin
      test_checks++;
      assert (exp_q.size() > 0) else begin
        $display("Unexpected response at %0t: no read was outstanding", $time);
        test_errors++;
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        check_value("rsp_o.rdata", rsp_o.rdata, want.rdata);
        check_value("rsp_o.err", {31'd0, rsp_o.err}, {31'd0, want.err});
        check_value("rsp_valid_o cycle", cyc, want.cyc);
      end
    end
  end

  initial begin
    int                    fd;
    int                    n;
    int                    waited;
    int                    t;
    string                 line;
    logic [7:0]            op;
    logic [`L2_ADDR_W-1:0] addr;
    logic [`L2_DATA_W-1:0] wdata;
    logic [`L2_DATA_W-1:0] exp_rdata;
    logic                  exp_err;
    reset_i     = 1'b1;
    clear_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    wait_ready(waited);
    check_value("ready_o low cycles", 32'(waited), 32'(`L2_BANK_ROWS + 1));

    fd = $fopen("dv/l2_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file dv/l2_trace.txt");
      test_errors++;
      abort = 1'b1;
    end
    while (!abort && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%d %c %h %h %h %h", t, op, addr, wdata, exp_rdata, exp_err);
      if (n != 6) begin
        $display("Malformed trace line: %s", line);
        test_errors++;
        continue;
      end
      if (t != cur_test) begin
        drain_responses();
        end_test();
        cur_test = t;
      end
      if (!abort) wait_ready(waited);
      if (abort) break;
      case (op)
        "W": issue_request(1'b1, addr, wdata);
        "R": begin
          exp_q.push_back('{rdata: exp_rdata, err: exp_err, cyc: cyc + 32'd2});
          issue_request(1'b0, addr, '0);
        end
        "C": run_clear(addr, wdata);
        default: begin
          $display("Unknown trace operation %c", op);
          test_errors++;
        end
      endcase
    end
    if (fd != 0) $fclose(fd);
    if (!abort) begin
      drain_responses();
      // Quiet cycles so a stray late response is still seen
      repeat (4) @(posedge clk_i);
    end
    end_test();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: dv/l2_trace.txt
# Columns: test, op (W write, R read, C clear), address, write data,
# expected read data, expected err. Unused fields are zero.
1 R 0000 00000000 00000000 0
1 R 01fc 00000000 00000000 0
1 R 1000 00000000 00000000 0
1 R 11fc 00000000 00000000 0
2 W 0000 a5a50001 00000000 0
2 W 0004 a5a50002 00000000 0
2 W 0008 a5a50003 00000000 0
2 W 01fc a5a50004 00000000 0
2 R 0000 00000000 a5a50001 0
2 R 0004 00000000 a5a50002 0
2 R 01fc 00000000 a5a50004 0
3 R 1000 00000000 a5a50001 0
3 R 1100 00000000 a5a50002 0
3 R 1004 00000000 a5a50003 0
3 R 11fc 00000000 a5a50004 0
3 W 1008 c3c30010 00000000 0
3 W 1104 c3c3000c 00000000 0
3 R 0010 00000000 c3c30010 0
3 R 000c 00000000 c3c3000c 0
4 R 0200 00000000 00000000 1
4 R 1200 00000000 00000000 1
4 W 0ffc deadbeef 00000000 0
4 W 0200 deadbeef 00000000 0
4 R 0000 00000000 a5a50001 0
5 C 0000 5a5a5a5a 00000000 0
5 R 0000 00000000 00000000 0
5 R 1008 00000000 00000000 0
6 W 0020 11110020 00000000 0
6 R 0020 00000000 11110020 0
6 W 0024 22220024 00000000 0
6 R 0024 00000000 22220024 0
6 R 1010 00000000 11110020 0
6 R fffc 00000000 00000000 1
6 R 0023 00000000 11110020 0

// File: list.f
+incdir+hdl
hdl/l2_pkg.sv
hdl/l2_addr_map.sv
hdl/l2_init_fsm.sv
hdl/l2_row_counter.sv
hdl/l2_bank.sv
hdl/l2_top.sv
dv/l2_props.sv
dv/l2_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the L2 scratchpad testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module l2_tb -f list.f \
  -Mdir obj_dir -o l2_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/l2_sim > sim.log 2>&1
cat sim.log

grep -qx "TEST OK" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }
